// File: periph_subsys.f
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/obi_to_reg.sv
rtl/reg_demux.sv
rtl/gpio_ctrl.sv
rtl/mtimer.sv
rtl/irq_ctrl.sv
rtl/periph_subsys.sv
tb/tb_periph_subsys.sv

// File: tb/tb_periph_subsys.sv
/*
 * Testbench for the peripheral subsystem. Builds a table of bus accesses,
 * pin and line changes, and expected values, then applies it in a loop.
 */
`timescale 1ns/100ps

module tb_periph_subsys
  import bus_pkg::*;
  import periph_pkg::*;
();

  localparam int    GPIO_W     = 16;
  localparam int    NEXT_INT   = 4;
  localparam gpio_t PIN_MASK   = (32'd1 << GPIO_W) - 32'd1;
  localparam data_t FULL       = 32'hffff_ffff;
  localparam addr_t IRQ_BASE   = 32'h0000_0000;
  localparam addr_t GPIO_BASE  = 32'h0000_1000;
  localparam addr_t TIMER_BASE = 32'h0000_2000;
  localparam addr_t NOMAP_BASE = 32'h0000_3000;
  localparam int    TIMER_ID   = GPIO_W + 1;
  localparam int    EXT_ID0    = GPIO_W + 2;

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_READ2, OP_POLL, OP_SET_PINS, OP_SET_EXT, OP_WAIT
  } op_e;

  // READ2 reads addr then addr+4, expecting exp then data
  // POLL repeats a read at most data times
  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    data_t exp;
    data_t mask;
    logic  irq;
    logic  tmr;
    logic  msip;
  } entry_t;

  logic                clk_i;
  logic                rst_i;
  obi_req_t            slave_req_i;
  obi_resp_t           slave_resp_o;
  logic [NEXT_INT-1:0] intr_ext_i;
  logic                irq_plic_o;
  irq_id_t             claim_id_o;
  logic                msip_o;
  gpio_t               gpio_i;
  gpio_t               gpio_o;
  gpio_t               gpio_en_o;
  logic                timer_intr_o;

  entry_t table_q[$];
  integer seed;
  logic   table_ready;
  gpio_t  out_exp;
  gpio_t  en_exp;

  periph_subsys periph_subsys_i (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t act, input data_t exp);
    if (act !== exp) begin
      $display("Fail %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t act, input gpio_t exp);
    if (act !== exp) begin
      $display("Fail %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input string name, input irq_id_t act, input irq_id_t exp);
    if (act !== exp) begin
      $display("Fail %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("Fail %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  // Called at a falling edge, returns at the falling edge carrying rvalid
  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata);
    slave_req_i.req   = 1'b1;
    slave_req_i.we    = we;
    slave_req_i.be    = '1;
    slave_req_i.addr  = addr;
    slave_req_i.wdata = wdata;
    #1;
    check_bit("gnt", slave_resp_o.gnt, 1'b1);
    @(negedge clk_i);
    check_bit("rvalid", slave_resp_o.rvalid, 1'b1);
    rdata = slave_resp_o.rdata;
  endtask

  task automatic bus_idle();
    slave_req_i.req = 1'b0;
    slave_req_i.we  = 1'b0;
  endtask

  task automatic poll_reg(input entry_t e);
    data_t rd;
    bit    found;
    found = 1'b0;
    for (int i = 0; i < e.data && !found; i++) begin
      @(negedge clk_i);
      bus_access(1'b0, e.addr, '0, rd);
      bus_idle();
      found = ((rd & e.mask) == (e.exp & e.mask));
    end
    if (!found) begin
      $display("Polling address %h never returned the expected value %h", e.addr, e.exp);
      abort_run();
    end
  endtask

  task automatic add_entry(input op_e op, input addr_t addr, input data_t data,
                           input data_t exp, input data_t mask,
                           input logic irq, input logic tmr, input logic msip);
    entry_t e;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    e.mask = mask;
    e.irq  = irq;
    e.tmr  = tmr;
    e.msip = msip;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    data_t rnd0;
    data_t rnd1;
    data_t rnd2;
    rnd0 = $random(seed);
    rnd1 = $random(seed);
    rnd2 = $random(seed);
    // Reset values
    add_entry(OP_READ, TIMER_BASE + 4*TIMER_COMPARE, 0, FULL, FULL, 0, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_DATA_OUT, 0, 0, FULL, 0, 0, 0);
    // GPIO outputs
    add_entry(OP_WRITE, GPIO_BASE + 4*GPIO_DATA_OUT, rnd0, 0, 0, 0, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_DATA_OUT, 0, rnd0 & PIN_MASK, FULL, 0, 0, 0);
    add_entry(OP_WRITE, GPIO_BASE + 4*GPIO_OUT_EN, rnd1, 0, 0, 0, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_OUT_EN, 0, rnd1 & PIN_MASK, FULL, 0, 0, 0);
    // Pins 0 and 2 rise, only pin 2 (ID 3) enabled
    add_entry(OP_WRITE, GPIO_BASE + 4*GPIO_INTR_EN, 32'h4, 0, 0, 0, 0, 0);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 32'h8, 0, 0, 0, 0, 0);
    add_entry(OP_SET_PINS, 0, 32'h5, 0, 0, 0, 0, 0);
    add_entry(OP_POLL, GPIO_BASE + 4*GPIO_DATA_IN, 20, 32'h5, PIN_MASK, 1, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_INTR_STATUS, 0, 32'h5, FULL, 1, 0, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_CLAIM, 0, 3, FULL, 1, 0, 0);
    add_entry(OP_WRITE, GPIO_BASE + 4*GPIO_INTR_STATUS, 32'h4, 0, 0, 0, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_INTR_STATUS, 0, 32'h1, FULL, 0, 0, 0);
    add_entry(OP_WRITE, GPIO_BASE + 4*GPIO_INTR_STATUS, 32'h1, 0, 0, 0, 0, 0);
    // Timer, prescale 1 and compare 40
    add_entry(OP_WRITE, TIMER_BASE + 4*TIMER_COMPARE, 40, 0, 0, 0, 0, 0);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 32'h1 << TIMER_ID, 0, 0, 0, 0, 0);
    add_entry(OP_WRITE, TIMER_BASE + 4*TIMER_CTRL, 32'h0101, 0, 0, 0, 0, 0);
    add_entry(OP_POLL, TIMER_BASE + 4*TIMER_COUNT, 40, 32'h8, 32'h8, 0, 0, 0);
    add_entry(OP_POLL, IRQ_BASE + 4*IRQ_PENDING, 100, 32'h1 << TIMER_ID,
              32'h1 << TIMER_ID, 1, 1, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_CLAIM, 0, TIMER_ID, FULL, 1, 1, 0);
    // Registered interrupt lags the disable by one cycle
    add_entry(OP_WRITE, TIMER_BASE + 4*TIMER_CTRL, 0, 0, 0, 1, 1, 0);
    add_entry(OP_WAIT, 0, 2, 0, 0, 0, 0, 0);
    // External lines at IDs 18, 19 and 21
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 0, 0, 0, 0, 0, 0);
    add_entry(OP_SET_EXT, 0, 32'hb, 0, 0, 0, 0, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_PENDING, 0, 32'hb << EXT_ID0, FULL, 0, 0, 0);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 32'ha << EXT_ID0, 0, 0, 1, 0, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_CLAIM, 0, EXT_ID0 + 1, FULL, 1, 0, 0);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 32'h8 << EXT_ID0, 0, 0, 1, 0, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_CLAIM, 0, EXT_ID0 + 3, FULL, 1, 0, 0);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_ENABLE, 0, 0, 0, 0, 0, 0);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_CLAIM, 0, 0, FULL, 0, 0, 0);
    add_entry(OP_SET_EXT, 0, 0, 0, 0, 0, 0, 0);
    // Software interrupt
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_MSIP, 1, 0, 0, 0, 0, 1);
    add_entry(OP_READ, IRQ_BASE + 4*IRQ_MSIP, 0, 1, FULL, 0, 0, 1);
    add_entry(OP_WRITE, IRQ_BASE + 4*IRQ_MSIP, 0, 0, 0, 0, 0, 0);
    // Unmapped index 3 at offset 1
    add_entry(OP_WRITE, NOMAP_BASE + 4, rnd2, 0, 0, 0, 0, 0);
    add_entry(OP_READ, NOMAP_BASE + 4, 0, 0, FULL, 0, 0, 0);
    add_entry(OP_READ, GPIO_BASE + 4*GPIO_DATA_OUT, 0, rnd0 & PIN_MASK, FULL, 0, 0, 0);
    add_entry(OP_READ, TIMER_BASE + 4*TIMER_COMPARE, 0, 40, FULL, 0, 0, 0);
    // DATA_OUT then OUT_EN on consecutive cycles
    add_entry(OP_READ2, GPIO_BASE + 4*GPIO_DATA_OUT, rnd1 & PIN_MASK, rnd0 & PIN_MASK,
              FULL, 0, 0, 0);
  endtask

  task automatic apply_entry(input entry_t e);
    data_t rd;
    data_t rd2;
    @(negedge clk_i);
    case (e.op)
      OP_WRITE: begin
        check_bit("rvalid", slave_resp_o.rvalid, 1'b0);
        bus_access(1'b1, e.addr, e.data, rd);
        bus_idle();
        check_data("rdata", rd, '0);
        if (e.addr == GPIO_BASE + 4*GPIO_DATA_OUT) begin
          out_exp = e.data & PIN_MASK;
        end
        if (e.addr == GPIO_BASE + 4*GPIO_OUT_EN) begin
          en_exp = e.data & PIN_MASK;
        end
      end
      OP_READ: begin
        check_bit("rvalid", slave_resp_o.rvalid, 1'b0);
        bus_access(1'b0, e.addr, '0, rd);
        bus_idle();
        check_data("rdata", rd & e.mask, e.exp & e.mask);
        if (e.addr == IRQ_BASE + 4*IRQ_CLAIM) begin
          check_id("claim_id_o", claim_id_o, irq_id_t'(e.exp));
        end
      end
      OP_READ2: begin
        check_bit("rvalid", slave_resp_o.rvalid, 1'b0);
        bus_access(1'b0, e.addr, '0, rd);
        bus_access(1'b0, e.addr + 4, '0, rd2);
        bus_idle();
        check_data("rdata", rd & e.mask, e.exp & e.mask);
        check_data("rdata", rd2 & e.mask, e.data & e.mask);
      end
      OP_POLL:     poll_reg(e);
      OP_SET_PINS: gpio_i = e.data;
      OP_SET_EXT:  intr_ext_i = e.data[NEXT_INT-1:0];
      default:     repeat (e.data) @(negedge clk_i);
    endcase
    #1;
    check_bit("irq_plic_o", irq_plic_o, e.irq);
    check_bit("timer_intr_o", timer_intr_o, e.tmr);
    check_bit("msip_o", msip_o, e.msip);
    check_gpio("gpio_o", gpio_o, out_exp);
    check_gpio("gpio_en_o", gpio_en_o, en_exp);
  endtask

  initial begin
    int budget;
    wait (table_ready === 1'b1);
    budget = 0;
    foreach (table_q[i]) begin
      budget += 1;
      if (table_q[i].op == OP_WAIT) begin
        budget += table_q[i].data;
      end
    end
    repeat (budget * 20) @(posedge clk_i);
    $display("Watchdog expired before the test sequence finished");
    abort_run();
  end

  initial begin
    seed        = 32'h3e9a3821;
    table_ready = 1'b0;
    rst_i       = 1'b1;
    slave_req_i = '0;
    gpio_i      = '0;
    intr_ext_i  = '0;
    out_exp     = '0;
    en_exp      = '0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_periph_subsys

// File: rtl/periph_subsys.sv
/*
 * Peripheral subsystem top. One OBI slave port reaches the interrupt
 * controller, GPIO and machine timer through a register-bus decoder.
 */
`timescale 1ns/100ps

module periph_subsys
  import bus_pkg::*;
  import periph_pkg::*;
#(
  parameter int GPIO_W   = 16,
  parameter int NEXT_INT = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,

  input  obi_req_t            slave_req_i,
  output obi_resp_t           slave_resp_o,

  // Interrupts
  input  logic [NEXT_INT-1:0] intr_ext_i,
  output logic                irq_plic_o,
  output irq_id_t             claim_id_o,
  output logic                msip_o,

  // GPIO pins
  input  gpio_t               gpio_i,
  output gpio_t               gpio_o,
  output gpio_t               gpio_en_o,

  output logic                timer_intr_o
);

  localparam int NUM_SRC = GPIO_W + NEXT_INT + 2;

  reg_req_t           periph_req, irq_req, gpio_req, timer_req;
  reg_rsp_t           periph_rsp, irq_rsp, gpio_rsp, timer_rsp;
  logic [GPIO_W-1:0]  gpio_intr;
  logic [NUM_SRC-1:0] intr_vector;

  // ID 0 tied low, then GPIO pins, timer and external lines
  assign intr_vector = {intr_ext_i, timer_intr_o, gpio_intr, 1'b0};

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i  (periph_req),
    .reg_rsp_o  (periph_rsp),
    .irq_req_o  (irq_req),
    .gpio_req_o (gpio_req),
    .timer_req_o(timer_req),
    .irq_rsp_i  (irq_rsp),
    .gpio_rsp_i (gpio_rsp),
    .timer_rsp_i(timer_rsp)
  );

  gpio_ctrl #(
    .GPIO_W(GPIO_W)
  ) gpio_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_req_i(gpio_req),
    .reg_rsp_o(gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o   (gpio_intr)
  );

  mtimer mtimer_i (
    .clk_i,
    .rst_i,
    .reg_req_i(timer_req),
    .reg_rsp_o(timer_rsp),
    .intr_o   (timer_intr_o)
  );

  irq_ctrl #(
    .NUM_SRC(NUM_SRC)
  ) irq_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_req_i (irq_req),
    .reg_rsp_o (irq_rsp),
    .intr_src_i(intr_vector),
    .irq_o     (irq_plic_o),
    .claim_id_o,
    .msip_o
  );

endmodule : periph_subsys

// File: rtl/irq_ctrl.sv
/*
 * Interrupt controller with an enable mask over level sources, a claim
 * register giving the lowest enabled pending ID, and a software interrupt.
 */
`timescale 1ns/100ps

module irq_ctrl
  import bus_pkg::*;
  import periph_pkg::*;
#(
  parameter int NUM_SRC = 22
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  reg_req_t           reg_req_i,
  output reg_rsp_t           reg_rsp_o,
  input  logic [NUM_SRC-1:0] intr_src_i,
  output logic               irq_o,
  output irq_id_t            claim_id_o,
  output logic               msip_o
);

  localparam data_t SRC_MASK = (32'd1 << NUM_SRC) - 32'd1;

  data_t    enable_q;
  data_t    pending, active;
  irq_id_t  claim_id;
  logic     msip_q;
  logic     wr;
  reg_off_t off;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign off = get_off(reg_req_i.addr);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= '0;
      msip_q   <= 1'b0;
    end else begin
      if (wr && off == IRQ_ENABLE) begin
        enable_q <= apply_strb(enable_q, reg_req_i.wdata, reg_req_i.wstrb) & SRC_MASK;
      end
      if (wr && off == IRQ_MSIP && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  // ID 0 never pends
  always_comb begin
    pending             = '0;
    pending[NUM_SRC-1:0] = intr_src_i;
    pending[0]          = 1'b0;
  end

  assign active = pending & enable_q;

  // Scan down so the lowest active ID is kept
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = irq_id_t'(i);
      end
    end
  end

  always_comb begin
    case (off)
      IRQ_ENABLE:  reg_rsp_o.rdata = enable_q;
      IRQ_PENDING: reg_rsp_o.rdata = pending;
      IRQ_CLAIM:   reg_rsp_o.rdata = data_t'(claim_id);
      IRQ_MSIP:    reg_rsp_o.rdata = data_t'(msip_q);
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o      = |active;
  assign claim_id_o = claim_id;
  assign msip_o     = msip_q;

endmodule : irq_ctrl

// File: rtl/mtimer.sv
/*
 * Machine timer, a prescaled 32-bit counter with a compare register and a
 * registered expiry interrupt.
 */
`timescale 1ns/100ps

module mtimer
  import bus_pkg::*;
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     intr_o
);

  data_t       count_q, compare_q;
  timer_ctrl_t ctrl_q;
  logic [7:0]  tick_q;
  logic        intr_q;
  logic        wr;
  reg_off_t    off;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign off = get_off(reg_req_i.addr);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q   <= '0;
      compare_q <= '1;
      ctrl_q    <= '0;
      tick_q    <= '0;
      intr_q    <= 1'b0;
    end else begin
      // Count once every prescale+1 cycles
      if (!ctrl_q.en || tick_q == ctrl_q.prescale) begin
        tick_q <= '0;
      end else begin
        tick_q <= tick_q + 8'd1;
      end
      if (wr && off == TIMER_COUNT) begin
        count_q <= apply_strb(count_q, reg_req_i.wdata, reg_req_i.wstrb);
      end else if (ctrl_q.en && tick_q == ctrl_q.prescale) begin
        count_q <= count_q + 32'd1;
      end
      if (wr && off == TIMER_COMPARE) begin
        compare_q <= apply_strb(compare_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && off == TIMER_CTRL) begin
        ctrl_q <= timer_ctrl_t'(apply_strb(ctrl_q, reg_req_i.wdata, reg_req_i.wstrb)
                  & TIMER_CTRL_MASK);
      end
      intr_q <= ctrl_q.en && (count_q >= compare_q);
    end
  end

  always_comb begin
    case (off)
      TIMER_COUNT:   reg_rsp_o.rdata = count_q;
      TIMER_COMPARE: reg_rsp_o.rdata = compare_q;
      TIMER_CTRL:    reg_rsp_o.rdata = ctrl_q;
      default:       reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o = intr_q;

endmodule : mtimer

// File: rtl/gpio_ctrl.sv
/*
 * GPIO block with output data and enable registers, synchronized inputs
 * and rising-edge interrupts with write-one-to-clear status.
 */
`timescale 1ns/100ps

module gpio_ctrl
  import bus_pkg::*;
  import periph_pkg::*;
#(
  parameter int GPIO_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  reg_req_t          reg_req_i,
  output reg_rsp_t          reg_rsp_o,
  input  gpio_t             gpio_i,
  output gpio_t             gpio_o,
  output gpio_t             gpio_en_o,
  output logic [GPIO_W-1:0] intr_o
);

  localparam gpio_t PIN_MASK = (32'd1 << GPIO_W) - 32'd1;

  gpio_t    sync1_q, sync2_q, data_in_q;
  gpio_t    data_out_q, out_en_q, intr_en_q, status_q;
  gpio_t    rise, w1c, intr_lvl;
  logic     wr;
  reg_off_t off;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign off = get_off(reg_req_i.addr);

  // Third flop doubles as the edge reference
  assign rise = sync2_q & ~data_in_q;
  assign w1c  = (wr && off == GPIO_INTR_STATUS) ? apply_strb('0, reg_req_i.wdata,
                reg_req_i.wstrb) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      data_in_q  <= '0;
      data_out_q <= '0;
      out_en_q   <= '0;
      intr_en_q  <= '0;
      status_q   <= '0;
    end else begin
      sync1_q   <= gpio_i & PIN_MASK;
      sync2_q   <= sync1_q;
      data_in_q <= sync2_q;
      if (wr && off == GPIO_DATA_OUT) begin
        data_out_q <= apply_strb(data_out_q, reg_req_i.wdata, reg_req_i.wstrb) & PIN_MASK;
      end
      if (wr && off == GPIO_OUT_EN) begin
        out_en_q <= apply_strb(out_en_q, reg_req_i.wdata, reg_req_i.wstrb) & PIN_MASK;
      end
      if (wr && off == GPIO_INTR_EN) begin
        intr_en_q <= apply_strb(intr_en_q, reg_req_i.wdata, reg_req_i.wstrb) & PIN_MASK;
      end
      // New edge beats a clear
      status_q <= ((status_q & ~w1c) | rise) & PIN_MASK;
    end
  end

  always_comb begin
    case (off)
      GPIO_DATA_IN:     reg_rsp_o.rdata = data_in_q;
      GPIO_DATA_OUT:    reg_rsp_o.rdata = data_out_q;
      GPIO_OUT_EN:      reg_rsp_o.rdata = out_en_q;
      GPIO_INTR_EN:     reg_rsp_o.rdata = intr_en_q;
      GPIO_INTR_STATUS: reg_rsp_o.rdata = status_q;
      default:          reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_lvl  = status_q & intr_en_q;
  assign intr_o    = intr_lvl[GPIO_W-1:0];
  assign gpio_o    = data_out_q;
  assign gpio_en_o = out_en_q;

endmodule : gpio_ctrl

// File: rtl/reg_demux.sv
/*
 * Routes a register-bus access to the interrupt controller, GPIO or timer
 * by address bits 13:12. Unmapped accesses read zero and drop writes.
 */
`timescale 1ns/100ps

module reg_demux
  import bus_pkg::*;
  import periph_pkg::*;
(
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output reg_req_t irq_req_o,
  output reg_req_t gpio_req_o,
  output reg_req_t timer_req_o,
  input  reg_rsp_t irq_rsp_i,
  input  reg_rsp_t gpio_rsp_i,
  input  reg_rsp_t timer_rsp_i
);

  periph_sel_t sel;

  assign sel = get_sel(reg_req_i.addr);

  // Same request to all, valid only toward the selected target
  always_comb begin
    irq_req_o         = reg_req_i;
    gpio_req_o        = reg_req_i;
    timer_req_o       = reg_req_i;
    irq_req_o.valid   = reg_req_i.valid && (sel == IRQ_IDX);
    gpio_req_o.valid  = reg_req_i.valid && (sel == GPIO_IDX);
    timer_req_o.valid = reg_req_i.valid && (sel == TIMER_IDX);
  end

  always_comb begin
    case (sel)
      IRQ_IDX: begin
        reg_rsp_o = irq_rsp_i;
      end
      GPIO_IDX: begin
        reg_rsp_o = gpio_rsp_i;
      end
      TIMER_IDX: begin
        reg_rsp_o = timer_rsp_i;
      end
      default: begin
        reg_rsp_o.rdata = '0;
      end
    endcase
  end

endmodule : reg_demux

// File: rtl/obi_to_reg.sv
/*
 * OBI slave port to single-cycle register bus. Grants every request and
 * returns rvalid with registered read data one cycle later.
 */
`timescale 1ns/100ps

module obi_to_reg
  import bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic  rvalid_q;
  data_t rdata_q;

  // No back-pressure, register bus is always ready
  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= obi_req_i.we ? '0 : reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o.gnt    = obi_req_i.req;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule : obi_to_reg

// File: rtl/periph_pkg.sv
/*
 * Address map, register offsets and interrupt numbering of the peripheral
 * subsystem. Decoder and peripherals import it.
 */
package periph_pkg;

  typedef logic [1:0]  periph_sel_t;
  typedef logic [2:0]  reg_off_t;
  typedef logic [4:0]  irq_id_t;
  typedef logic [31:0] gpio_t;

  // Peripheral index from address bits 13:12, index 3 unmapped
  localparam periph_sel_t IRQ_IDX   = 2'd0;
  localparam periph_sel_t GPIO_IDX  = 2'd1;
  localparam periph_sel_t TIMER_IDX = 2'd2;

  localparam reg_off_t GPIO_DATA_IN     = 3'd0;
  localparam reg_off_t GPIO_DATA_OUT    = 3'd1;
  localparam reg_off_t GPIO_OUT_EN      = 3'd2;
  localparam reg_off_t GPIO_INTR_EN     = 3'd3;
  localparam reg_off_t GPIO_INTR_STATUS = 3'd4;

  localparam reg_off_t TIMER_COUNT   = 3'd0;
  localparam reg_off_t TIMER_COMPARE = 3'd1;
  localparam reg_off_t TIMER_CTRL    = 3'd2;

  localparam reg_off_t IRQ_ENABLE  = 3'd0;
  localparam reg_off_t IRQ_PENDING = 3'd1;
  localparam reg_off_t IRQ_CLAIM   = 3'd2;
  localparam reg_off_t IRQ_MSIP    = 3'd3;

  // ID of GPIO pin 0, ID 0 stays tied to zero
  localparam int GPIO_IRQ_BASE = 1;

  // Timer CTRL layout, enable in bit 0 and prescale in 15:8
  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [7:0]  prescale;
    logic [6:0]  rsvd_lo;
    logic        en;
  } timer_ctrl_t;

  localparam logic [31:0] TIMER_CTRL_MASK = 32'h0000_ff01;

  function automatic periph_sel_t get_sel(logic [31:0] addr);
    return addr[13:12];
  endfunction

  function automatic reg_off_t get_off(logic [31:0] addr);
    return addr[4:2];
  endfunction

endpackage : periph_pkg

// File: rtl/bus_pkg.sv
/*
 * Bus widths and the OBI and register-bus structs shared by the bridge,
 * the decoder and every peripheral.
 */
package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Core side, OBI request and response
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  // Register bus, always ready
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
  } reg_rsp_t;

  // Merge write data into a register under byte enables
  function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b+:8] = new_val[8*b+:8];
      end
    end
    return res;
  endfunction

endpackage : bus_pkg
